//--- src.f
+incdir+source
source/video_pkg.sv
source/wb_pkg.sv
source/wb_delay_line.sv
source/wb_stat_accum.sv
source/wb_divider.sv
source/wb_gain_calc.sv
source/wb_pixel_scale.sv
source/wb_top.sv
sim/tb_clock.sv
sim/wb_tb.sv

//--- sim/wb_tb.sv
`timescale 1ns/10ps
`include "wb_defs.svh"

module wb_tb;

    localparam int LINES          = 4;
    localparam int ACTIVE         = 16;
    localparam int HBLANK         = 4;
    localparam int VBLANK         = 200;
    localparam int NPIX           = LINES * ACTIVE;
    localparam int FRAME_CYCLES   = LINES * (ACTIVE + HBLANK) + VBLANK;
    localparam int NUM_FRAMES     = 6;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_CYCLES + 500;

    logic                 clk;
    logic                 i_rst;
    logic                 i_wb_en;
    logic                 i_vsync;
    logic                 i_hsync;
    logic                 i_de;
    logic [`WB_PIX_W-1:0] i_r;
    logic [`WB_PIX_W-1:0] i_g;
    logic [`WB_PIX_W-1:0] i_b;
    logic                 o_vsync;
    logic                 o_hsync;
    logic                 o_de;
    logic [`WB_PIX_W-1:0] o_r;
    logic [`WB_PIX_W-1:0] o_g;
    logic [`WB_PIX_W-1:0] o_b;
    logic                 o_gain_valid;
    wb_pkg::gain_t        o_gain_r;
    wb_pkg::gain_t        o_gain_g;
    wb_pkg::gain_t        o_gain_b;

    integer            seed;
    video_pkg::pixel_t frame_pix [NPIX];
    longint            sum_r;
    longint            sum_g;
    longint            sum_b;
    logic              last_vsync;
    logic              gain_pending;    // A captured frame still waits for its gain strobe
    wb_pkg::gain_t     exp_gain_r;
    wb_pkg::gain_t     exp_gain_g;
    wb_pkg::gain_t     exp_gain_b;
    wb_pkg::gain_t     model_gain_r;
    wb_pkg::gain_t     model_gain_g;
    wb_pkg::gain_t     model_gain_b;
    wb_pkg::gain_t     captured_gain_r;
    wb_pkg::gain_t     captured_gain_g;
    wb_pkg::gain_t     captured_gain_b;
    int                gain_updates;
    int                clip_count;
    int                cycle_count;
    logic              pipe_valid [2];
    video_pkg::pixel_t pipe_pix [2];
    video_pkg::sync_t  pipe_sync [2];
    video_pkg::pixel_t next_pix;

    tb_clock clock0 (
        .clk(clk)
    );

    wb_top dut0 (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_wb_en     (i_wb_en),
        .i_vsync     (i_vsync),
        .i_hsync     (i_hsync),
        .i_de        (i_de),
        .i_r         (i_r),
        .i_g         (i_g),
        .i_b         (i_b),
        .o_vsync     (o_vsync),
        .o_hsync     (o_hsync),
        .o_de        (o_de),
        .o_r         (o_r),
        .o_g         (o_g),
        .o_b         (o_b),
        .o_gain_valid(o_gain_valid),
        .o_gain_r    (o_gain_r),
        .o_gain_g    (o_gain_g),
        .o_gain_b    (o_gain_b)
    );

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("CHECK FAILED at time %0t: %s expected %0d, actual %0d",
                 $time, name, expected, actual);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at time %0t: %s", $time, msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    // Output pixel is the product with the fraction dropped, limited to full scale
    function automatic int scaled_value(input int pix, input int gain);
        int full;
        full = (pix * gain) / (2 ** `WB_GAIN_FRAC);
        if (full > 255) begin
            return 255;
        end
        return full;
    endfunction

    function automatic logic exceeds_full_scale(input int pix, input int gain);
        return ((pix * gain) / (2 ** `WB_GAIN_FRAC)) > 255;
    endfunction

    // Gray-world gain from the total of all channels and one channel sum
    function automatic wb_pkg::gain_t ref_gain(input longint total, input longint chan);
        longint q;
        if (chan == 0) begin
            return `WB_GAIN_MAX;
        end
        q = (total * (2 ** `WB_GAIN_FRAC)) / (3 * chan);
        if (q > longint'(`WB_GAIN_MAX)) begin
            return `WB_GAIN_MAX;
        end
        return wb_pkg::gain_t'(q);
    endfunction

    // Drives one stream cycle and keeps the frame sums the DUT should see
    task automatic drive_cycle(input logic vs, input logic hs, input logic de,
                               input video_pkg::pixel_t pix);
        @(negedge clk);
        i_vsync = vs;
        i_hsync = hs;
        i_de    = de;
        i_r     = pix.r;
        i_g     = pix.g;
        i_b     = pix.b;
        if (vs && !last_vsync) begin
            if (i_wb_en) begin
                exp_gain_r   = ref_gain(sum_r + sum_g + sum_b, sum_r);
                exp_gain_g   = ref_gain(sum_r + sum_g + sum_b, sum_g);
                exp_gain_b   = ref_gain(sum_r + sum_g + sum_b, sum_b);
                gain_pending = 1'b1;
            end
            sum_r = 0; // The edge cycle itself is never counted
            sum_g = 0;
            sum_b = 0;
        end else if (de) begin
            sum_r = sum_r + pix.r;
            sum_g = sum_g + pix.g;
            sum_b = sum_b + pix.b;
        end
        last_vsync = vs;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            drive_cycle(1'b0, 1'b0, 1'b0, '0);
        end
    endtask

    task automatic fill_random(input logic blue_zero);
        logic [31:0] rnd;
        for (int i = 0; i < NPIX; i++) begin
            rnd          = $random(seed);
            frame_pix[i] = rnd[23:0];
            if (blue_zero) begin
                frame_pix[i].b = '0;
            end
        end
    endtask

    task automatic fill_constant(input logic [7:0] r, input logic [7:0] g, input logic [7:0] b);
        for (int i = 0; i < NPIX; i++) begin
            frame_pix[i].r = r;
            frame_pix[i].g = g;
            frame_pix[i].b = b;
        end
    endtask

    // Active lines with short hsync pulses, then vertical blanking with vsync
    task automatic send_frame();
        int idx;
        idx = 0;
        for (int line = 0; line < LINES; line++) begin
            for (int x = 0; x < ACTIVE + HBLANK; x++) begin
                if (x < ACTIVE) begin
                    drive_cycle(1'b0, 1'b0, 1'b1, frame_pix[idx]);
                    idx++;
                end else begin
                    drive_cycle(1'b0, (x == ACTIVE + 1) || (x == ACTIVE + 2), 1'b0, '0);
                end
            end
        end
        for (int v = 0; v < VBLANK; v++) begin
            drive_cycle((v >= 2) && (v < 6), 1'b0, 1'b0, '0);
        end
        assert (!gain_pending)
            else report_error("No gain update arrived within the vertical blanking");
    endtask

    task automatic unity_after_reset();
        assert (o_gain_r === `WB_GAIN_ONE)
            else report_mismatch("o_gain_r", `WB_GAIN_ONE, o_gain_r);
        assert (o_gain_g === `WB_GAIN_ONE)
            else report_mismatch("o_gain_g", `WB_GAIN_ONE, o_gain_g);
        assert (o_gain_b === `WB_GAIN_ONE)
            else report_mismatch("o_gain_b", `WB_GAIN_ONE, o_gain_b);
        assert (o_gain_valid === 1'b0) else report_mismatch("o_gain_valid", 0, o_gain_valid);
        fill_random(1'b0);
        send_frame(); // With unity gains the monitor expects output equal to input
    endtask

    task automatic constant_colour_gains();
        int            updates_before;
        wb_pkg::gain_t want_r;
        wb_pkg::gain_t want_g;
        wb_pkg::gain_t want_b;
        updates_before = gain_updates;
        fill_constant(8'd200, 8'd100, 8'd50);
        send_frame();
        assert (gain_updates == updates_before + 1)
            else report_error("The constant colour frame did not give exactly one gain update");
        want_r = ref_gain(NPIX * 350, NPIX * 200);
        want_g = ref_gain(NPIX * 350, NPIX * 100);
        want_b = ref_gain(NPIX * 350, NPIX * 50);
        assert (captured_gain_r === want_r)
            else report_mismatch("o_gain_r", want_r, captured_gain_r);
        assert (captured_gain_g === want_g)
            else report_mismatch("o_gain_g", want_g, captured_gain_g);
        assert (captured_gain_b === want_b)
            else report_mismatch("o_gain_b", want_b, captured_gain_b);
    endtask

    task automatic random_frame_scaling();
        int clips_before;
        clips_before = clip_count;
        fill_random(1'b0);
        send_frame();
        assert (clip_count > clips_before)
            else report_error("No output pixel of the scaled frame was clipped at 255");
    endtask

    task automatic missing_blue_channel();
        int updates_before;
        updates_before = gain_updates;
        fill_random(1'b1);
        send_frame();
        assert (gain_updates == updates_before + 1)
            else report_error("The frame without blue did not give exactly one gain update");
        assert (captured_gain_b === `WB_GAIN_MAX)
            else report_mismatch("o_gain_b", `WB_GAIN_MAX, captured_gain_b);
    endtask

    task automatic bypass_while_disabled();
        int            updates_before;
        wb_pkg::gain_t keep_r;
        wb_pkg::gain_t keep_g;
        wb_pkg::gain_t keep_b;
        keep_r         = o_gain_r;
        keep_g         = o_gain_g;
        keep_b         = o_gain_b;
        updates_before = gain_updates;
        idle_cycles(1);
        i_wb_en = 1'b0;
        fill_random(1'b0);
        send_frame();
        assert (gain_updates == updates_before)
            else report_error("A gain update arrived while white balance was disabled");
        idle_cycles(1);
        i_wb_en = 1'b1;
        idle_cycles(2);
        assert (o_gain_r === keep_r) else report_mismatch("o_gain_r", keep_r, o_gain_r);
        assert (o_gain_g === keep_g) else report_mismatch("o_gain_g", keep_g, o_gain_g);
        assert (o_gain_b === keep_b) else report_mismatch("o_gain_b", keep_b, o_gain_b);
        fill_random(1'b0);
        send_frame();
    endtask

    // Output seen at a rising edge belongs to the input sampled two edges earlier
    always @(posedge clk) begin
        if (pipe_valid[1]) begin
            assert (o_vsync === pipe_sync[1].vsync)
                else report_mismatch("o_vsync", pipe_sync[1].vsync, o_vsync);
            assert (o_hsync === pipe_sync[1].hsync)
                else report_mismatch("o_hsync", pipe_sync[1].hsync, o_hsync);
            assert (o_de === pipe_sync[1].de) else report_mismatch("o_de", pipe_sync[1].de, o_de);
            assert (o_r === pipe_pix[1].r) else report_mismatch("o_r", pipe_pix[1].r, o_r);
            assert (o_g === pipe_pix[1].g) else report_mismatch("o_g", pipe_pix[1].g, o_g);
            assert (o_b === pipe_pix[1].b) else report_mismatch("o_b", pipe_pix[1].b, o_b);
        end
        next_pix.r = i_wb_en ? scaled_value(i_r, model_gain_r) : i_r;
        next_pix.g = i_wb_en ? scaled_value(i_g, model_gain_g) : i_g;
        next_pix.b = i_wb_en ? scaled_value(i_b, model_gain_b) : i_b;
        if (i_wb_en && i_de && (exceeds_full_scale(i_r, model_gain_r) ||
                                exceeds_full_scale(i_g, model_gain_g) ||
                                exceeds_full_scale(i_b, model_gain_b))) begin
            clip_count++;
        end
        pipe_valid[1] = pipe_valid[0];
        pipe_pix[1]   = pipe_pix[0];
        pipe_sync[1]  = pipe_sync[0];
        pipe_valid[0] = !i_rst;
        pipe_pix[0]   = next_pix;
        pipe_sync[0]  = '{vsync: i_vsync, hsync: i_hsync, de: i_de};
        // New gains take effect for the pixel after the strobe
        if (!i_rst && o_gain_valid === 1'b1) begin
            assert (gain_pending)
                else report_error("A gain update arrived without a captured frame");
            assert (o_gain_r === exp_gain_r)
                else report_mismatch("o_gain_r", exp_gain_r, o_gain_r);
            assert (o_gain_g === exp_gain_g)
                else report_mismatch("o_gain_g", exp_gain_g, o_gain_g);
            assert (o_gain_b === exp_gain_b)
                else report_mismatch("o_gain_b", exp_gain_b, o_gain_b);
            captured_gain_r = o_gain_r;
            captured_gain_g = o_gain_g;
            captured_gain_b = o_gain_b;
            model_gain_r    = exp_gain_r;
            model_gain_g    = exp_gain_g;
            model_gain_b    = exp_gain_b;
            gain_pending    = 1'b0;
            gain_updates++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_error($sformatf("Timeout, the tests did not finish within %0d clock cycles",
                                   TIMEOUT_CYCLES));
        end
    end

    initial begin
        seed            = 32'h3d03446b;
        i_rst           = 1'b1;
        i_wb_en         = 1'b1;
        i_vsync         = 1'b0;
        i_hsync         = 1'b0;
        i_de            = 1'b0;
        i_r             = '0;
        i_g             = '0;
        i_b             = '0;
        sum_r           = 0;
        sum_g           = 0;
        sum_b           = 0;
        last_vsync      = 1'b0;
        gain_pending    = 1'b0;
        exp_gain_r      = `WB_GAIN_ONE;
        exp_gain_g      = `WB_GAIN_ONE;
        exp_gain_b      = `WB_GAIN_ONE;
        model_gain_r    = `WB_GAIN_ONE;
        model_gain_g    = `WB_GAIN_ONE;
        model_gain_b    = `WB_GAIN_ONE;
        captured_gain_r = `WB_GAIN_ONE;
        captured_gain_g = `WB_GAIN_ONE;
        captured_gain_b = `WB_GAIN_ONE;
        gain_updates    = 0;
        clip_count      = 0;
        cycle_count     = 0;
        pipe_valid      = '{1'b0, 1'b0};
        repeat (5) @(negedge clk);
        i_rst = 1'b0;
        idle_cycles(4);
        unity_after_reset();
        constant_colour_gains();
        random_frame_scaling();
        missing_blue_channel();
        bypass_while_disabled();
        idle_cycles(4); // Let the last outputs leave the pipeline
        $display("All tests passed");
        $finish;
    end

endmodule : wb_tb

//--- sim/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule : tb_clock

//--- source/wb_top.sv
`timescale 1ns/10ps
`include "wb_defs.svh"

module wb_top (
    input  logic                 clk,
    input  logic                 i_rst,
    input  logic                 i_wb_en,
    input  logic                 i_vsync,
    input  logic                 i_hsync,
    input  logic                 i_de,
    input  logic [`WB_PIX_W-1:0] i_r,
    input  logic [`WB_PIX_W-1:0] i_g,
    input  logic [`WB_PIX_W-1:0] i_b,
    output logic                 o_vsync,
    output logic                 o_hsync,
    output logic                 o_de,
    output logic [`WB_PIX_W-1:0] o_r,
    output logic [`WB_PIX_W-1:0] o_g,
    output logic [`WB_PIX_W-1:0] o_b,
    output logic                 o_gain_valid,
    output wb_pkg::gain_t        o_gain_r,
    output wb_pkg::gain_t        o_gain_g,
    output wb_pkg::gain_t        o_gain_b
);

    logic         sums_valid;
    wb_pkg::sum_t sum_r;
    wb_pkg::sum_t sum_g;
    wb_pkg::sum_t sum_b;

    wb_stat_accum u_stat_accum (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_wb_en     (i_wb_en),
        .i_vsync     (i_vsync),
        .i_de        (i_de),
        .i_r         (i_r),
        .i_g         (i_g),
        .i_b         (i_b),
        .o_sums_valid(sums_valid),
        .o_sum_r     (sum_r),
        .o_sum_g     (sum_g),
        .o_sum_b     (sum_b)
    );

    wb_gain_calc u_gain_calc (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_sums_valid(sums_valid),
        .i_sum_r     (sum_r),
        .i_sum_g     (sum_g),
        .i_sum_b     (sum_b),
        .o_gain_valid(o_gain_valid),
        .o_gain_r    (o_gain_r),
        .o_gain_g    (o_gain_g),
        .o_gain_b    (o_gain_b)
    );

    wb_pixel_scale u_pixel_scale (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_wb_en     (i_wb_en),
        .i_gain_valid(o_gain_valid),
        .i_gain_r    (o_gain_r),
        .i_gain_g    (o_gain_g),
        .i_gain_b    (o_gain_b),
        .i_vsync     (i_vsync),
        .i_hsync     (i_hsync),
        .i_de        (i_de),
        .i_r         (i_r),
        .i_g         (i_g),
        .i_b         (i_b),
        .o_vsync     (o_vsync),
        .o_hsync     (o_hsync),
        .o_de        (o_de),
        .o_r         (o_r),
        .o_g         (o_g),
        .o_b         (o_b)
    );

endmodule : wb_top

//--- source/wb_pixel_scale.sv
`timescale 1ns/10ps
`include "wb_defs.svh"

module wb_pixel_scale (
    input  logic                 clk,
    input  logic                 i_rst,
    input  logic                 i_wb_en,
    input  logic                 i_gain_valid,
    input  wb_pkg::gain_t        i_gain_r,
    input  wb_pkg::gain_t        i_gain_g,
    input  wb_pkg::gain_t        i_gain_b,
    input  logic                 i_vsync,
    input  logic                 i_hsync,
    input  logic                 i_de,
    input  logic [`WB_PIX_W-1:0] i_r,
    input  logic [`WB_PIX_W-1:0] i_g,
    input  logic [`WB_PIX_W-1:0] i_b,
    output logic                 o_vsync,
    output logic                 o_hsync,
    output logic                 o_de,
    output logic [`WB_PIX_W-1:0] o_r,
    output logic [`WB_PIX_W-1:0] o_g,
    output logic [`WB_PIX_W-1:0] o_b
);

    localparam int PROD_W = `WB_PIX_W + `WB_GAIN_W;

    wb_pkg::gain_t        gain_r;
    wb_pkg::gain_t        gain_g;
    wb_pkg::gain_t        gain_b;
    logic [PROD_W-1:0]    prod_r;
    logic [PROD_W-1:0]    prod_g;
    logic [PROD_W-1:0]    prod_b;
    logic [`WB_PIX_W-1:0] sat_r;
    logic [`WB_PIX_W-1:0] sat_g;
    logic [`WB_PIX_W-1:0] sat_b;
    logic                 en_d1;
    logic                 en_d2;
    video_pkg::pixel_t    pix_in;
    video_pkg::pixel_t    pix_raw;
    video_pkg::sync_t     sync_in;
    video_pkg::sync_t     sync_out;

    // Drop the fraction bits and clip at full scale
    function automatic logic [`WB_PIX_W-1:0] sat_pix(input logic [PROD_W-1:0] p);
        logic [PROD_W-1:0] q;
        q = p >> `WB_GAIN_FRAC;
        if (|q[PROD_W-1:`WB_PIX_W]) begin
            return '1;
        end
        return q[`WB_PIX_W-1:0];
    endfunction

    always_ff @(posedge clk) begin
        if (i_rst) begin
            gain_r <= #1 `WB_GAIN_ONE;
            gain_g <= #1 `WB_GAIN_ONE;
            gain_b <= #1 `WB_GAIN_ONE;
            en_d1  <= #1 1'b0;
            en_d2  <= #1 1'b0;
        end else begin
            if (i_gain_valid) begin // Arrives in blanking, so a frame never sees two gain sets
                gain_r <= #1 i_gain_r;
                gain_g <= #1 i_gain_g;
                gain_b <= #1 i_gain_b;
            end
            en_d1 <= #1 i_wb_en;
            en_d2 <= #1 en_d1;
        end
    end

    always_ff @(posedge clk) begin
        prod_r <= #1 i_r * gain_r;
        prod_g <= #1 i_g * gain_g;
        prod_b <= #1 i_b * gain_b;
        sat_r  <= #1 sat_pix(prod_r);
        sat_g  <= #1 sat_pix(prod_g);
        sat_b  <= #1 sat_pix(prod_b);
    end

    assign pix_in  = '{r: i_r, g: i_g, b: i_b};
    assign sync_in = '{vsync: i_vsync, hsync: i_hsync, de: i_de};

    wb_delay_line #(
        .payload_t(video_pkg::pixel_t),
        .DEPTH    (2)
    ) u_raw_delay (
        .clk   (clk),
        .i_rst (i_rst),
        .i_data(pix_in),
        .o_data(pix_raw)
    );

    wb_delay_line #(
        .payload_t(video_pkg::sync_t),
        .DEPTH    (2)
    ) u_sync_delay (
        .clk   (clk),
        .i_rst (i_rst),
        .i_data(sync_in),
        .o_data(sync_out)
    );

    assign o_vsync = sync_out.vsync;
    assign o_hsync = sync_out.hsync;
    assign o_de    = sync_out.de;

    assign o_r = en_d2 ? sat_r : pix_raw.r; // Bypass follows the enable seen with this pixel
    assign o_g = en_d2 ? sat_g : pix_raw.g;
    assign o_b = en_d2 ? sat_b : pix_raw.b;

endmodule : wb_pixel_scale

//--- source/wb_gain_calc.sv
`timescale 1ns/10ps
`include "wb_defs.svh"

module wb_gain_calc (
    input  logic          clk,
    input  logic          i_rst,
    input  logic          i_sums_valid,
    input  wb_pkg::sum_t  i_sum_r,
    input  wb_pkg::sum_t  i_sum_g,
    input  wb_pkg::sum_t  i_sum_b,
    output logic          o_gain_valid,
    output wb_pkg::gain_t o_gain_r,
    output wb_pkg::gain_t o_gain_g,
    output wb_pkg::gain_t o_gain_b
);

    localparam int DVSR_W = `WB_SUM_W + 2;
    localparam int FULL_W = DVSR_W + `WB_GAIN_FRAC;
    localparam int NORM_SH = FULL_W - `WB_DIV_W; // Drop needed when the dividend overflows

    typedef enum logic [1:0] {ST_IDLE, ST_START, ST_WAIT} state_t;

    state_t            state;
    logic [1:0]        ch;
    logic [DVSR_W-1:0] total;
    logic [FULL_W-1:0] total_sh;
    logic              too_wide;
    wb_pkg::quot_t     dividend;
    logic [DVSR_W-1:0] dvsr_r;
    logic [DVSR_W-1:0] dvsr_g;
    logic [DVSR_W-1:0] dvsr_b;
    logic [DVSR_W-1:0] dvsr_sel;
    logic              div_start;
    logic              div_done;
    wb_pkg::quot_t     quotient;
    wb_pkg::gain_t     gain_clamped;
    wb_pkg::gain_t     stage_r;
    wb_pkg::gain_t     stage_g;

    function automatic logic [DVSR_W-1:0] times3(input wb_pkg::sum_t s);
        return {1'b0, s, 1'b0} + {2'b00, s};
    endfunction

    assign total    = {2'b00, i_sum_r} + {2'b00, i_sum_g} + {2'b00, i_sum_b};
    assign total_sh = {total, {`WB_GAIN_FRAC{1'b0}}};
    assign too_wide = |total_sh[FULL_W-1:`WB_DIV_W];

    assign div_start    = (state == ST_START);
    assign dvsr_sel     = (ch == 2'd0) ? dvsr_r : (ch == 2'd1) ? dvsr_g : dvsr_b;
    assign gain_clamped = (quotient > `WB_GAIN_MAX) ? `WB_GAIN_MAX : quotient[`WB_GAIN_W-1:0];

    wb_divider #(
        .DVSR_W(DVSR_W)
    ) u_divider (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_start   (div_start),
        .i_dividend(dividend),
        .i_divisor (dvsr_sel),
        .o_done    (div_done),
        .o_quotient(quotient)
    );

    // Operands are latched so a later sums strobe cannot disturb a running update
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && i_sums_valid) begin
            if (too_wide) begin // Huge frames scale both sides down, keeping the ratio
                dividend <= #1 wb_pkg::quot_t'(total_sh >> NORM_SH);
                dvsr_r   <= #1 times3(i_sum_r) >> NORM_SH;
                dvsr_g   <= #1 times3(i_sum_g) >> NORM_SH;
                dvsr_b   <= #1 times3(i_sum_b) >> NORM_SH;
            end else begin
                dividend <= #1 total_sh[`WB_DIV_W-1:0];
                dvsr_r   <= #1 times3(i_sum_r);
                dvsr_g   <= #1 times3(i_sum_g);
                dvsr_b   <= #1 times3(i_sum_b);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state        <= #1 ST_IDLE;
            ch           <= #1 2'd0;
            o_gain_valid <= #1 1'b0;
            o_gain_r     <= #1 `WB_GAIN_ONE;
            o_gain_g     <= #1 `WB_GAIN_ONE;
            o_gain_b     <= #1 `WB_GAIN_ONE;
            stage_r      <= #1 `WB_GAIN_ONE;
            stage_g      <= #1 `WB_GAIN_ONE;
        end else begin
            o_gain_valid <= #1 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_sums_valid) begin
                        ch    <= #1 2'd0;
                        state <= #1 ST_START;
                    end
                end
                ST_START: state <= #1 ST_WAIT;
                ST_WAIT: begin
                    if (div_done) begin
                        case (ch)
                            2'd0: stage_r <= #1 gain_clamped;
                            2'd1: stage_g <= #1 gain_clamped;
                            default: begin // Blue is last, all three gains change together
                                o_gain_r     <= #1 stage_r;
                                o_gain_g     <= #1 stage_g;
                                o_gain_b     <= #1 gain_clamped;
                                o_gain_valid <= #1 1'b1;
                            end
                        endcase
                        if (ch == 2'd2) begin
                            state <= #1 ST_IDLE;
                        end else begin
                            ch    <= #1 ch + 2'd1;
                            state <= #1 ST_START;
                        end
                    end
                end
                default: state <= #1 ST_IDLE;
            endcase
        end
    end

endmodule : wb_gain_calc

//--- source/wb_divider.sv
`timescale 1ns/10ps
`include "wb_defs.svh"

module wb_divider #(
    parameter int DVSR_W = `WB_SUM_W + 2
) (
    input  logic              clk,
    input  logic              i_rst,
    input  logic              i_start,
    input  wb_pkg::quot_t     i_dividend,
    input  logic [DVSR_W-1:0] i_divisor,
    output logic              o_done,
    output wb_pkg::quot_t     o_quotient
);

    localparam int CNT_W = $clog2(`WB_DIV_W);

    logic              busy;
    logic [CNT_W-1:0]  bit_cnt;
    logic [DVSR_W-1:0] dvsr;
    logic [DVSR_W-1:0] rem;
    wb_pkg::quot_t     work;     // Dividend leaves at the top while quotient bits enter below
    logic [DVSR_W:0]   trial;
    logic [DVSR_W+1:0] diff;
    logic              borrow;

    assign trial  = {rem, work[`WB_DIV_W-1]};
    assign diff   = {1'b0, trial} - {2'b00, dvsr};
    assign borrow = diff[DVSR_W+1];

    always_ff @(posedge clk) begin
        if (i_rst) begin
            busy    <= #1 1'b0;
            bit_cnt <= #1 '0;
            o_done  <= #1 1'b0;
        end else begin
            o_done <= #1 1'b0;
            if (busy) begin
                bit_cnt <= #1 bit_cnt + 1'b1;
                if (bit_cnt == CNT_W'(`WB_DIV_W - 1)) begin
                    busy   <= #1 1'b0;
                    o_done <= #1 1'b1;
                end
            end else if (i_start) begin
                busy    <= #1 1'b1;
                bit_cnt <= #1 '0;
            end
        end
    end

    // A zero divisor never borrows, so every quotient bit comes out as one
    always_ff @(posedge clk) begin
        if (!busy && i_start) begin
            dvsr <= #1 i_divisor;
            rem  <= #1 '0;
            work <= #1 i_dividend;
        end else if (busy) begin
            rem  <= #1 borrow ? trial[DVSR_W-1:0] : diff[DVSR_W-1:0];
            work <= #1 {work[`WB_DIV_W-2:0], !borrow};
        end
    end

    assign o_quotient = work; // Stable from o_done until the next start

endmodule : wb_divider

//--- source/wb_stat_accum.sv
`timescale 1ns/10ps
`include "wb_defs.svh"

module wb_stat_accum (
    input  logic                 clk,
    input  logic                 i_rst,
    input  logic                 i_wb_en,
    input  logic                 i_vsync,
    input  logic                 i_de,
    input  logic [`WB_PIX_W-1:0] i_r,
    input  logic [`WB_PIX_W-1:0] i_g,
    input  logic [`WB_PIX_W-1:0] i_b,
    output logic                 o_sums_valid,
    output wb_pkg::sum_t         o_sum_r,
    output wb_pkg::sum_t         o_sum_g,
    output wb_pkg::sum_t         o_sum_b
);

    logic         vsync_d;
    logic         frame_edge;
    wb_pkg::sum_t acc_r;
    wb_pkg::sum_t acc_g;
    wb_pkg::sum_t acc_b;

    assign frame_edge = i_vsync && !vsync_d; // Start of vertical sync closes the frame

    always_ff @(posedge clk) begin
        if (i_rst) begin
            vsync_d <= #1 1'b0;
        end else begin
            vsync_d <= #1 i_vsync;
        end
    end

    // A pixel that coincides with the edge belongs to no frame
    always_ff @(posedge clk) begin
        if (i_rst || frame_edge) begin
            acc_r <= #1 '0;
            acc_g <= #1 '0;
            acc_b <= #1 '0;
        end else if (i_de) begin
            acc_r <= #1 acc_r + wb_pkg::sum_t'(i_r);
            acc_g <= #1 acc_g + wb_pkg::sum_t'(i_g);
            acc_b <= #1 acc_b + wb_pkg::sum_t'(i_b);
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_sums_valid <= #1 1'b0;
            o_sum_r      <= #1 '0;
            o_sum_g      <= #1 '0;
            o_sum_b      <= #1 '0;
        end else begin
            o_sums_valid <= #1 1'b0;
            if (frame_edge && i_wb_en) begin
                o_sums_valid <= #1 1'b1;
                o_sum_r      <= #1 acc_r;
                o_sum_g      <= #1 acc_g;
                o_sum_b      <= #1 acc_b;
            end
        end
    end

endmodule : wb_stat_accum

//--- source/wb_delay_line.sv
`timescale 1ns/10ps

module wb_delay_line #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 2
) (
    input  logic     clk,
    input  logic     i_rst,
    input  payload_t i_data,
    output payload_t o_data
);

    payload_t stages [DEPTH];

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stages[i] <= #1 '0;
            end
        end else begin
            stages[0] <= #1 i_data;
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= #1 stages[i-1];
            end
        end
    end

    assign o_data = stages[DEPTH-1];

endmodule : wb_delay_line

//--- source/wb_pkg.sv
`include "wb_defs.svh"

package wb_pkg;

    // Sum of one channel over all active pixels of a frame
    typedef logic [`WB_SUM_W-1:0] sum_t;

    // Channel gain with WB_GAIN_FRAC fraction bits where WB_GAIN_ONE is unity
    typedef logic [`WB_GAIN_W-1:0] gain_t;

    // Dividend and quotient of the serial divider
    typedef logic [`WB_DIV_W-1:0] quot_t;

endpackage : wb_pkg

//--- source/video_pkg.sv
`include "wb_defs.svh"

package video_pkg;

    // One RGB pixel as it travels down the stream
    typedef struct packed {
        logic [`WB_PIX_W-1:0] r;
        logic [`WB_PIX_W-1:0] g;
        logic [`WB_PIX_W-1:0] b;
    } pixel_t;

    // Timing signals that accompany every pixel
    typedef struct packed {
        logic vsync;
        logic hsync;
        logic de;
    } sync_t;

endpackage : video_pkg

//--- source/wb_defs.svh
`ifndef WB_DEFS_SVH
`define WB_DEFS_SVH

// Width of one colour channel
`define WB_PIX_W 8

// Per-channel frame sum wide enough for 1280x720 pixels at full scale
`define WB_SUM_W 28

// Gains are unsigned fixed point with WB_GAIN_FRAC fraction bits
`define WB_GAIN_W    16
`define WB_GAIN_FRAC 8

`define WB_GAIN_ONE 16'd256 // Unity gain
`define WB_GAIN_MAX 16'hFFFF // Saturation value that also stands for an empty channel

// Dividend and quotient width of the serial divider
`define WB_DIV_W 32

`endif
